// File: hdl/sm83_alu_pkg.sv
package sm83_alu_pkg;

	typedef enum logic [4:0] {
		ADD,			// A + B
		ADC,			// A + B + C
		SUB,			// A - B
		SBC,			// A - B - C
		CP,				// Compare, flags of A - B
		AND,
		OR,
		XOR,
		INC,			// A + 1
		DEC,			// A - 1
		RLC,			// Rotate left circular
		RRC,			// Rotate right circular
		RL,				// Rotate left through carry
		RR,				// Rotate right through carry
		SLA,			// Shift left, zero fill
		SRA,			// Shift right, sign kept
		SRL,			// Shift right, zero fill
		SWAP,			// Exchange nibbles of B
		BIT,			// Test bit of B
		SET,			// Set bit of A
		RES,			// Clear bit of A
		CPL,			// Complement A
		CCF,			// Flip carry
		SCF,			// Force carry
		NOP
	} alu_op_e;

	// Bit positions in the flags vector
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 2;
	localparam int FLAG_H = 1;
	localparam int FLAG_C = 0;

	typedef enum logic [1:0] {
		COND_NZ,		// Z clear
		COND_Z,			// Z set
		COND_NC,		// C clear
		COND_C			// C set
	} cond_e;

endpackage

// File: hdl/alu_shifter.sv
module alu_shifter (
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            operand_b,
	input  logic                  carry_flag,	// Registered C for RL/RR
	output logic [7:0]            perm,			// Permuted B, zero for non-shift ops
	output logic                  shift_out		// Bit leaving the byte
);
	import sm83_alu_pkg::*;

	logic sel_left;		// RLC, RL, SLA
	logic sel_right;	// RRC, RR, SRA, SRL
	logic sel_rlc;
	logic sel_rl;
	logic sel_rrc;
	logic sel_rr;
	logic sel_sra;
	logic sel_swap;

	assign sel_rlc   = (op == RLC);
	assign sel_rl    = (op == RL);
	assign sel_rrc   = (op == RRC);
	assign sel_rr    = (op == RR);
	assign sel_sra   = (op == SRA);
	assign sel_swap  = (op == SWAP);
	assign sel_left  = sel_rlc | sel_rl | (op == SLA);
	assign sel_right = sel_rrc | sel_rr | sel_sra | (op == SRL);

	// LSB comb, SLA leaves it zero
	assign perm[0] = (sel_rlc & operand_b[7]) | (sel_right & operand_b[1]) |
		(sel_swap & operand_b[4]) | (sel_rl & carry_flag);

	// Middle bits see only neighbour or swap partner
	for (genvar i = 1; i < 7; i++) begin : g_mid
		assign perm[i] = (sel_left & operand_b[i-1]) | (sel_right & operand_b[i+1]) |
			(sel_swap & operand_b[(i+4)%8]);
	end

	// MSB comb, SRL leaves it zero
	assign perm[7] = (sel_left & operand_b[6]) | (sel_rr & carry_flag) |
		(sel_sra & operand_b[7]) | (sel_rrc & operand_b[0]) | (sel_swap & operand_b[3]);

	assign shift_out = (sel_left & operand_b[7]) | (sel_right & operand_b[0]);	// SWAP gives 0

endmodule

// File: hdl/alu_gp_terms.sv
module alu_gp_terms (
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            opnd1,		// Prepared operand 1
	input  logic [7:0]            operand_b,
	input  logic [7:0]            perm,			// Shifter result
	input  logic                  b_cpl,		// Invert operand 2 for subtract
	output logic [7:0]            opnd2,
	output logic [7:0]            g,			// Generate terms
	output logic [7:0]            p,			// Propagate terms
	output logic [7:0]            x_term,
	output logic [7:0]            logic_res		// Bypass into the sum combine
);
	import sm83_alu_pkg::*;

	logic       sel_incdec;
	logic       sel_and;
	logic       sel_or;
	logic       sel_opnd1;	// SET, RES, CPL pass operand 1
	logic [7:0] b_src;

	assign sel_incdec = (op == INC) || (op == DEC);
	assign sel_and    = (op == AND);
	assign sel_or     = (op == OR);
	assign sel_opnd1  = (op == SET) || (op == RES) || (op == CPL);

	assign b_src = sel_incdec ? 8'h00 : operand_b;	// INC/DEC add 0 or 0xFF
	assign opnd2 = b_src ^ {8{b_cpl}};

	assign g      = opnd1 & opnd2;	// Doubles as the AND result
	assign p      = opnd1 | opnd2;	// Doubles as the OR result
	assign x_term = opnd1 ^ opnd2;

	// Only one source is nonzero per op
	assign logic_res = ({8{sel_and}} & g) | ({8{sel_or}} & p) |
		({8{sel_opnd1}} & opnd1) | perm;

endmodule

// File: hdl/alu_carry_lookahead.sv
module alu_carry_lookahead (
	input  logic [3:0] g,
	input  logic [3:0] p,
	input  logic       cin,
	output logic [3:0] carry	// Carries out of bits 0..3
);

	// Each carry is a flat sum of products, no ripple between terms
	assign carry[0] = g[0] | (p[0] & cin);

	assign carry[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);

	assign carry[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
		(p[2] & p[1] & p[0] & cin);

	assign carry[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) |
		(p[3] & p[2] & p[1] & g[0]) |
		(p[3] & p[2] & p[1] & p[0] & cin);	// Nibble carry

endmodule

// File: hdl/alu_adder.sv
module alu_adder (
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            g,
	input  logic [7:0]            p,
	input  logic [7:0]            x_term,
	input  logic [7:0]            logic_res,
	input  logic                  carry_in,
	output logic [7:0]            res,
	output logic                  half_carry,	// Raw carry out of bit 3
	output logic                  carry_out		// Borrow for subtract ops
);
	import sm83_alu_pkg::*;

	logic       sel_sum;	// Arithmetic ops
	logic       sel_xor;
	logic       sel_sub;	// Ops with inverted operand 2
	logic [3:0] carry_lo;
	logic [3:0] carry_hi;
	logic [7:0] carry_vec;	// Carry into each bit
	logic [7:0] half_sum;
	logic [7:0] sum;

	assign sel_sum = (op == ADD) || (op == ADC) || (op == SUB) || (op == SBC) ||
		(op == CP) || (op == INC) || (op == DEC);
	assign sel_xor = (op == XOR);
	assign sel_sub = (op == SUB) || (op == SBC) || (op == CP) || (op == DEC);

	alu_carry_lookahead u_cla_lo (.g(g[3:0]), .p(p[3:0]), .cin(carry_in), .carry(carry_lo));
	alu_carry_lookahead u_cla_hi (.g(g[7:4]), .p(p[7:4]), .cin(carry_lo[3]), .carry(carry_hi));

	assign carry_vec = {carry_hi[2:0], carry_lo, carry_in};
	assign half_sum  = p & ~g;				// Propagate without generate
	assign sum       = half_sum ^ carry_vec;

	assign res = ({8{sel_sum}} & sum) | ({8{sel_xor}} & x_term) | logic_res;

	assign half_carry = carry_lo[3];
	assign carry_out  = sel_sum & (carry_hi[3] ^ sel_sub);	// Quiet outside arithmetic

endmodule

// File: hdl/alu_flag_logic.sv
module alu_flag_logic (
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            operand_a,
	input  logic [2:0]            bit_sel,
	input  sm83_alu_pkg::cond_e   cond,
	input  logic                  cc_check,
	input  logic [3:0]            flags,		// Registered Z/N/H/C
	input  logic [7:0]            res,
	input  logic [7:0]            opnd2,
	input  logic                  half_carry,
	input  logic                  carry_out,
	input  logic                  shift_out,
	output logic [7:0]            opnd1,
	output logic                  carry_in,
	output logic                  b_cpl,
	output logic [3:0]            flags_next,
	output logic [3:0]            flags_load,	// Per-flag write mask
	output logic                  cond_taken
);
	import sm83_alu_pkg::*;

	logic       sel_add_cls;	// ADD, ADC, INC
	logic       sel_sub_cls;	// SUB, SBC, CP, DEC
	logic       sel_bit;
	logic       sel_cpl;
	logic       no_load;		// SET, RES, NOP
	logic [7:0] bit_mask;
	logic       c_next;
	logic       cond_hit;

	assign sel_add_cls = (op == ADD) || (op == ADC) || (op == INC);
	assign sel_sub_cls = (op == SUB) || (op == SBC) || (op == CP) || (op == DEC);
	assign sel_bit     = (op == BIT);
	assign sel_cpl     = (op == CPL);
	assign no_load     = (op == SET) || (op == RES) || (op == NOP);
	assign bit_mask    = 8'h01 << bit_sel;

	always_comb begin
		case (op)
			SET:     opnd1 = operand_a | bit_mask;
			RES:     opnd1 = operand_a & ~bit_mask;
			CPL:     opnd1 = ~operand_a;
			ADD, ADC, SUB, SBC, CP, AND, OR, XOR, INC, DEC: opnd1 = operand_a;
			default: opnd1 = 8'h00;		// Shifts, BIT and flag ops use B only
		endcase
	end

	always_comb begin
		case (op)
			SUB, CP, INC: carry_in = 1'b1;			// Two's complement +1
			ADC:          carry_in = flags[FLAG_C];
			SBC:          carry_in = ~flags[FLAG_C];	// Borrow in as inverted carry
			default:      carry_in = 1'b0;
		endcase
	end

	assign b_cpl = sel_sub_cls;

	// BIT tests operand 2, which is plain B here
	assign flags_next[FLAG_Z] = sel_bit ? ~opnd2[bit_sel] : (res == 8'h00);
	assign flags_next[FLAG_N] = sel_sub_cls | sel_cpl;
	assign flags_next[FLAG_H] = (sel_add_cls & half_carry) | (sel_sub_cls & ~half_carry) |
		(op == AND) | sel_bit | sel_cpl;

	always_comb begin
		case (op)
			ADD, ADC, SUB, SBC, CP:                  c_next = carry_out;
			RLC, RRC, RL, RR, SLA, SRA, SRL, SWAP:   c_next = shift_out;
			CCF:                                     c_next = ~flags[FLAG_C];
			SCF:                                     c_next = 1'b1;
			default:                                 c_next = 1'b0;	// AND, OR, XOR
		endcase
	end

	assign flags_next[FLAG_C] = c_next;

	assign flags_load[FLAG_Z] = ~no_load & ~((op == CCF) || (op == SCF) || sel_cpl);
	assign flags_load[FLAG_N] = ~no_load;
	assign flags_load[FLAG_H] = ~no_load;
	assign flags_load[FLAG_C] = ~no_load & ~((op == INC) || (op == DEC) || sel_bit || sel_cpl);

	always_comb begin
		case (cond)
			COND_NZ: cond_hit = ~flags[FLAG_Z];
			COND_Z:  cond_hit = flags[FLAG_Z];
			COND_NC: cond_hit = ~flags[FLAG_C];
			default: cond_hit = flags[FLAG_C];	// COND_C
		endcase
	end

	assign cond_taken = cc_check & cond_hit;	// Only for conditional instructions

endmodule

// File: hdl/alu_flag_reg.sv
module alu_flag_reg (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       flag_we,		// Single-cycle write strobe
	input  logic [3:0] flags_load,
	input  logic [3:0] flags_next,
	output logic [3:0] flags
);
	import sm83_alu_pkg::*;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= 4'h0;
		end else if (flag_we) begin
			if (flags_load[FLAG_Z]) begin
				flags[FLAG_Z] <= flags_next[FLAG_Z];
			end
			if (flags_load[FLAG_N]) begin
				flags[FLAG_N] <= flags_next[FLAG_N];
			end
			if (flags_load[FLAG_H]) begin
				flags[FLAG_H] <= flags_next[FLAG_H];
			end
			if (flags_load[FLAG_C]) begin
				flags[FLAG_C] <= flags_next[FLAG_C];	// Kept for INC/DEC/BIT/CPL
			end
		end
	end

endmodule

// File: hdl/sm83_alu.sv
module sm83_alu (
	input  logic                  clk,
	input  logic                  arst_n,
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            operand_a,	// Operand 1, target of SET/RES/CPL
	input  logic [7:0]            operand_b,	// Operand 2, source of shifts and BIT
	input  logic [2:0]            bit_sel,
	input  sm83_alu_pkg::cond_e   cond,
	input  logic                  cc_check,
	input  logic                  flag_we,
	output logic [7:0]            res,
	output logic                  carry_out,
	output logic [3:0]            flags,
	output logic                  cond_taken
);
	import sm83_alu_pkg::*;

	logic [7:0] perm;
	logic       shift_out;
	logic [7:0] opnd1;
	logic       carry_in;
	logic       b_cpl;
	logic [7:0] opnd2;
	logic [7:0] g;
	logic [7:0] p;
	logic [7:0] x_term;
	logic [7:0] logic_res;
	logic       half_carry;
	logic [3:0] flags_next;
	logic [3:0] flags_load;

	alu_shifter u_shifter (
		.op(op), .operand_b(operand_b), .carry_flag(flags[FLAG_C]),
		.perm(perm), .shift_out(shift_out)
	);

	alu_flag_logic u_flag_logic (
		.op(op), .operand_a(operand_a), .bit_sel(bit_sel), .cond(cond),
		.cc_check(cc_check), .flags(flags), .res(res), .opnd2(opnd2),
		.half_carry(half_carry), .carry_out(carry_out), .shift_out(shift_out),
		.opnd1(opnd1), .carry_in(carry_in), .b_cpl(b_cpl),
		.flags_next(flags_next), .flags_load(flags_load), .cond_taken(cond_taken)
	);

	alu_gp_terms u_gp_terms (
		.op(op), .opnd1(opnd1), .operand_b(operand_b), .perm(perm), .b_cpl(b_cpl),
		.opnd2(opnd2), .g(g), .p(p), .x_term(x_term), .logic_res(logic_res)
	);

	alu_adder u_adder (
		.op(op), .g(g), .p(p), .x_term(x_term), .logic_res(logic_res),
		.carry_in(carry_in), .res(res), .half_carry(half_carry), .carry_out(carry_out)
	);

	alu_flag_reg u_flag_reg (
		.clk(clk), .arst_n(arst_n), .flag_we(flag_we), .flags_load(flags_load),
		.flags_next(flags_next), .flags(flags)
	);

endmodule

// File: test/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Bit that leaves the byte, SWAP and non-shifts give 0
function automatic logic shifted_bit(input alu_op_e o, input logic [7:0] b);
	case (o)
		RLC, RL, SLA:      return b[7];
		RRC, RR, SRA, SRL: return b[0];
		default:           return 1'b0;
	endcase
endfunction

function automatic logic [7:0] ref_result(input alu_op_e o, input logic [7:0] a,
	input logic [7:0] b, input logic [2:0] bs, input logic c);
	logic [7:0] mask;
	mask = 8'h01 << bs;
	case (o)
		ADD:     return a + b;
		ADC:     return a + b + {7'h00, c};
		SUB, CP: return a - b;				// CP still shows the difference
		SBC:     return a - b - {7'h00, c};
		INC:     return a + 8'h01;
		DEC:     return a - 8'h01;
		AND:     return a & b;
		OR:      return a | b;
		XOR:     return a ^ b;
		CPL:     return ~a;
		RLC:     return {b[6:0], b[7]};
		RRC:     return {b[0], b[7:1]};
		RL:      return {b[6:0], c};		// Old carry enters bit 0
		RR:      return {c, b[7:1]};
		SLA:     return {b[6:0], 1'b0};
		SRA:     return {b[7], b[7:1]};
		SRL:     return {1'b0, b[7:1]};
		SWAP:    return {b[3:0], b[7:4]};
		SET:     return a | mask;
		RES:     return a & ~mask;
		default: return 8'h00;				// BIT, CCF, SCF, NOP
	endcase
endfunction

// Full carry, or borrow for subtracts
function automatic logic carry_of(input alu_op_e o, input logic [7:0] a,
	input logic [7:0] b, input logic c);
	logic [8:0] wide_a;
	logic [8:0] wide_b;
	wide_a = {1'b0, a};
	wide_b = {1'b0, b};
	case (o)
		ADD:     return (wide_a + wide_b) > 9'h0FF;
		ADC:     return (wide_a + wide_b + {8'h00, c}) > 9'h0FF;
		SUB, CP: return wide_a < wide_b;
		SBC:     return wide_a < (wide_b + {8'h00, c});
		INC:     return a == 8'hFF;
		DEC:     return a == 8'h00;			// Borrow out of zero
		default: return 1'b0;
	endcase
endfunction

// H flag value
function automatic logic nibble_carry(input alu_op_e o, input logic [7:0] a,
	input logic [7:0] b, input logic c);
	logic [4:0] lo_a;
	logic [4:0] lo_b;
	lo_a = {1'b0, a[3:0]};
	lo_b = {1'b0, b[3:0]};
	case (o)
		ADD:           return (lo_a + lo_b) > 5'h0F;
		ADC:           return (lo_a + lo_b + {4'h0, c}) > 5'h0F;
		INC:           return a[3:0] == 4'hF;
		SUB, CP:       return lo_a < lo_b;
		SBC:           return lo_a < (lo_b + {4'h0, c});
		DEC:           return a[3:0] == 4'h0;
		AND, BIT, CPL: return 1'b1;
		default:       return 1'b0;
	endcase
endfunction

function automatic logic [3:0] next_flag_state(input alu_op_e o, input logic [7:0] a,
	input logic [7:0] b, input logic [2:0] bs, input logic [3:0] prev);
	logic [3:0] f;
	logic       c;
	f = prev;
	c = prev[FLAG_C];
	if (o inside {SET, RES, NOP}) begin
		return prev;								// Nothing loads
	end
	if (o == BIT) begin
		f[FLAG_Z] = ~b[bs];
	end else if (!(o inside {CPL, CCF, SCF})) begin
		f[FLAG_Z] = (ref_result(o, a, b, bs, c) == 8'h00);
	end
	f[FLAG_N] = o inside {SUB, SBC, CP, DEC, CPL};
	f[FLAG_H] = nibble_carry(o, a, b, c);
	case (o)
		ADD, ADC, SUB, SBC, CP:                f[FLAG_C] = carry_of(o, a, b, c);
		RLC, RRC, RL, RR, SLA, SRA, SRL, SWAP: f[FLAG_C] = shifted_bit(o, b);
		AND, OR, XOR:                          f[FLAG_C] = 1'b0;
		CCF:                                   f[FLAG_C] = ~c;
		SCF:                                   f[FLAG_C] = 1'b1;
		default:                               f[FLAG_C] = c;	// INC, DEC, BIT, CPL
	endcase
	return f;
endfunction

function automatic logic cond_holds(input cond_e cnd, input logic cc, input logic [3:0] f);
	logic hit;
	case (cnd)
		COND_NZ: hit = ~f[FLAG_Z];
		COND_Z:  hit = f[FLAG_Z];
		COND_NC: hit = ~f[FLAG_C];
		default: hit = f[FLAG_C];
	endcase
	return cc & hit;
endfunction

`endif

// File: test/tb_sm83_alu.sv
module tb_sm83_alu;
	import sm83_alu_pkg::*;

	`include "alu_model.svh"

	localparam int CLK_PERIOD        = 10;
	localparam int RESET_CYCLES      = 10;
	localparam int NUM_TESTS         = 6;
	localparam int VECTORS           = 120;	// Most vectors in one test
	localparam int CYCLES_PER_VECTOR = 3;		// Carry setup plus the op
	localparam int TIMEOUT = (NUM_TESTS * VECTORS * CYCLES_PER_VECTOR + RESET_CYCLES + 200) *
		CLK_PERIOD;

	logic        clk;
	logic        arst_n;
	alu_op_e     op;
	logic [7:0]  operand_a;
	logic [7:0]  operand_b;
	logic [2:0]  bit_sel;
	cond_e       cond;
	logic        cc_check;
	logic        flag_we;
	logic [7:0]  res;
	logic        carry_out;
	logic [3:0]  flags;
	logic        cond_taken;
	logic [31:0] seed;
	logic [3:0]  exp_flags;	// Tracked model flags
	int          errors;
	int          checks;
	int          err_mark;
	int          chk_mark;

	alu_op_e arith_ops [7] = '{ADD, ADC, SUB, SBC, CP, INC, DEC};
	alu_op_e logic_ops [6] = '{AND, OR, XOR, CPL, CCF, SCF};
	alu_op_e shift_ops [8] = '{RLC, RRC, RL, RR, SLA, SRA, SRL, SWAP};

	sm83_alu UUT (
		.clk(clk), .arst_n(arst_n), .op(op), .operand_a(operand_a), .operand_b(operand_b),
		.bit_sel(bit_sel), .cond(cond), .cc_check(cc_check), .flag_we(flag_we),
		.res(res), .carry_out(carry_out), .flags(flags), .cond_taken(cond_taken)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic log_mismatch(input string name, input logic [7:0] got, input logic [7:0] want);
		errors++;
		$display("error %s: got %h expected %h (op %s a %h b %h bit %0d) at %0t",
			name, got, want, op.name(), operand_a, operand_b, bit_sel, $time);
	endtask

	task automatic summarize_test(input string name);
		$display("test %-6s %4d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	// Called 1 unit after a rising edge, returns 1 unit after the next
	task automatic apply_op(input alu_op_e o, input logic [7:0] a, input logic [7:0] b,
		input logic [2:0] bs, input logic we);
		logic [7:0] want_res;
		logic       want_carry;
		logic       want_cond;
		logic [3:0] want_flags;
		seed = xorshift(seed);
		op        = o;
		operand_a = a;
		operand_b = b;
		bit_sel   = bs;
		flag_we   = we;
		cond      = cond_e'(seed[1:0]);	// Random branch check rides along
		cc_check  = seed[2];
		want_res   = ref_result(o, a, b, bs, exp_flags[FLAG_C]);
		want_carry = carry_of(o, a, b, exp_flags[FLAG_C]);
		want_cond  = cond_holds(cond, cc_check, exp_flags);
		want_flags = next_flag_state(o, a, b, bs, exp_flags);
		#4;									// Mid-cycle, outputs settled
		checks += 3;
		assert (res == want_res) else log_mismatch("res", res, want_res);
		assert (carry_out == want_carry)
			else log_mismatch("carry_out", {7'h00, carry_out}, {7'h00, want_carry});
		assert (cond_taken == want_cond)
			else log_mismatch("cond_taken", {7'h00, cond_taken}, {7'h00, want_cond});
		@(posedge clk);
		#1;
		if (we) begin
			exp_flags = want_flags;
		end
		checks++;
		assert (flags == exp_flags) else log_mismatch("flags", {4'h0, flags}, {4'h0, exp_flags});
	endtask

	// SCF, then CCF when a clear carry is wanted
	task automatic set_carry(input logic c);
		apply_op(SCF, seed[15:8], seed[23:16], seed[26:24], 1'b1);
		if (!c) begin
			apply_op(CCF, seed[15:8], seed[23:16], seed[26:24], 1'b1);
		end
	endtask

	task automatic sweep_conditions();
		logic want;
		for (int cc = 0; cc < 2; cc++) begin
			for (int k = 0; k < 4; k++) begin
				op       = NOP;
				flag_we  = 1'b0;
				cc_check = cc[0];
				cond     = cond_e'(k[1:0]);
				want     = cond_holds(cond, cc_check, exp_flags);
				#4;
				checks++;
				assert (cond_taken == want)
					else log_mismatch("cond_taken", {7'h00, cond_taken}, {7'h00, want});
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic reset_checks();
		checks++;
		assert (flags == 4'h0) else log_mismatch("flags", {4'h0, flags}, 8'h00);
		sweep_conditions();
	endtask

	task automatic arith_sweep();
		set_carry(1'b0);
		apply_op(INC, 8'hFF, 8'h00, 3'd0, 1'b1);		// Wraps to zero, C kept
		apply_op(DEC, 8'h00, 8'h00, 3'd0, 1'b1);		// Half borrow from zero
		apply_op(DEC, 8'h01, 8'h00, 3'd0, 1'b1);
		apply_op(CP, 8'h5A, 8'h5A, 3'd0, 1'b1);
		apply_op(SUB, 8'h10, 8'h01, 3'd0, 1'b1);
		apply_op(ADD, 8'h0F, 8'h01, 3'd0, 1'b1);
		apply_op(ADD, 8'h80, 8'h80, 3'd0, 1'b1);		// Carry with zero result
		set_carry(1'b1);
		apply_op(SBC, 8'h00, 8'hFF, 3'd0, 1'b1);		// Borrow in, wraps to zero
		apply_op(ADC, 8'hFF, 8'h00, 3'd0, 1'b1);
		for (int v = 0; v < VECTORS; v++) begin
			seed = xorshift(seed);
			set_carry(seed[31]);
			seed = xorshift(seed);
			apply_op(arith_ops[int'(seed[31:24]) % 7], seed[7:0], seed[15:8], seed[18:16],
				seed[20:19] != 2'b00);				// Some cycles skip the strobe
		end
	endtask

	task automatic logic_sweep();
		logic [7:0] a;
		logic [7:0] b;
		for (int v = 0; v < VECTORS; v++) begin
			seed = xorshift(seed);
			a = seed[7:0];
			case (seed[17:16])
				2'b00:   b = 8'h00;					// AND gives zero
				2'b01:   b = a;						// XOR gives zero
				default: b = seed[15:8];
			endcase
			apply_op(logic_ops[int'(seed[31:24]) % 6], a, b, seed[20:18], seed[22:21] != 2'b00);
		end
	endtask

	task automatic shift_sweep();
		logic [7:0] b;
		for (int s = 0; s < 8; s++) begin
			for (int v = 0; v < VECTORS / 8; v++) begin
				seed = xorshift(seed);
				set_carry(seed[31]);				// Carry-through for RL and RR
				case (v)
					0:       b = 8'h00;
					1:       b = 8'h80;
					2:       b = 8'h01;
					default: b = seed[15:8];
				endcase
				apply_op(shift_ops[s], seed[7:0], b, seed[18:16], 1'b1);
			end
		end
	endtask

	task automatic bit_sweep();
		logic [7:0] mask;
		for (int i = 0; i < 8; i++) begin
			mask = 8'h01 << i;
			seed = xorshift(seed);
			set_carry(seed[31]);
			apply_op(BIT, seed[7:0], seed[15:8] | mask, i[2:0], 1'b1);	// Bit set, Z clear
			apply_op(BIT, seed[7:0], seed[15:8] & ~mask, i[2:0], 1'b1);
			apply_op(SET, seed[23:16], seed[15:8], i[2:0], 1'b1);
			apply_op(RES, seed[23:16], seed[15:8], i[2:0], 1'b1);
		end
	endtask

	task automatic cond_sweep();
		apply_op(XOR, 8'h3C, 8'h3C, 3'd0, 1'b1);		// Z set, C clear
		sweep_conditions();
		apply_op(SCF, 8'h00, 8'h00, 3'd0, 1'b1);		// Z kept, C set
		sweep_conditions();
		apply_op(OR, 8'h01, 8'h00, 3'd0, 1'b1);			// Both clear
		sweep_conditions();
		apply_op(SCF, 8'h00, 8'h00, 3'd0, 1'b1);
		sweep_conditions();
	endtask

	assert property (@(posedge clk) !arst_n |-> flags == 4'h0)
		else log_mismatch("flags", {4'h0, flags}, 8'h00);

	assert property (@(posedge clk) disable iff (!arst_n) !cc_check |-> !cond_taken)
		else log_mismatch("cond_taken", {7'h00, cond_taken}, 8'h00);

	// No strobe, no flag change
	assert property (@(posedge clk) disable iff (!arst_n) !$past(flag_we) |-> flags == $past(flags))
		else begin
			errors++;
			$display("error flags: changed to %h with flag_we low at %0t", flags, $time);
		end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired after %0d time units before the tests finished", TIMEOUT);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		arst_n    = 1'b1;
		op        = NOP;
		operand_a = 8'h00;
		operand_b = 8'h00;
		bit_sel   = 3'd0;
		cond      = COND_NZ;
		cc_check  = 1'b0;
		flag_we   = 1'b0;
		seed      = 32'h2da0_6b67;
		exp_flags = 4'h0;
		errors    = 0;
		checks    = 0;
		err_mark  = 0;
		chk_mark  = 0;
		#1;
		arst_n = 1'b0;							// Real falling edge into reset
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_checks();
		summarize_test("reset");
		arith_sweep();
		summarize_test("arith");
		logic_sweep();
		summarize_test("logic");
		shift_sweep();
		summarize_test("shift");
		bit_sweep();
		summarize_test("bit");
		cond_sweep();
		summarize_test("cond");
		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+test
hdl/sm83_alu_pkg.sv
hdl/alu_shifter.sv
hdl/alu_gp_terms.sv
hdl/alu_carry_lookahead.sv
hdl/alu_adder.sv
hdl/alu_flag_logic.sv
hdl/alu_flag_reg.sv
hdl/sm83_alu.sv
test/tb_sm83_alu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sm83_alu
FLIST     = flist.f

OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
